/* common/logger_consts.svh */
`ifndef LOGGER_CONSTS_SVH
`define LOGGER_CONSTS_SVH

// Captured sample layout
`define LOG_SIG_WIDTH 16   // Watched signal, used for change detection
`define LOG_IGN_WIDTH 16   // Side field, carried along but never compared
`define LOG_WORD_WIDTH 32  // {side, sig}

// Packet framing
`define LOG_PACKET_SIZE 8  // Captured words per packet
`define LOG_PKT_WIDTH 3    // Holds 0 .. LOG_PACKET_SIZE-1

// Word FIFO
`define LOG_FIFO_DEPTH 16  // Power of two, pointers wrap naturally
`define LOG_LEVEL_WIDTH 5  // Holds 0 .. LOG_FIFO_DEPTH

// Output stream
`define LOG_BYTE_WIDTH 8

`endif

/* common/sample_pkg.sv */
`default_nettype none

`include "logger_consts.svh"

package sample_pkg;

  typedef logic [`LOG_SIG_WIDTH-1:0] sig_t;
  typedef logic [`LOG_IGN_WIDTH-1:0] side_t;

  // Side field in the upper half, watched signal in the lower half
  typedef struct packed {
    side_t side;
    sig_t  sig;
  } sample_word_t;

  // One FIFO slot, last marks the final word of a packet
  typedef struct packed {
    logic         last;
    sample_word_t word;
  } fifo_entry_t;

  typedef logic [`LOG_PKT_WIDTH-1:0] pkt_count_t;  // Word position in packet

endpackage

`default_nettype wire

/* common/stream_pkg.sv */
`default_nettype none

`include "logger_consts.svh"

package stream_pkg;

  // One byte on the output stream
  typedef logic [`LOG_BYTE_WIDTH-1:0] stream_byte_t;

  // Number of entries held in the word FIFO, 0 through full depth
  typedef logic [`LOG_LEVEL_WIDTH-1:0] fifo_level_t;

endpackage

`default_nettype wire

/* framer/change_framer.sv */
`default_nettype none

`include "logger_consts.svh"

module change_framer (
  input  wire logic               clock,
  input  wire logic               rst_i,
  input  wire logic               enable_i,
  input  wire sample_pkg::sig_t   sig_i,
  input  wire sample_pkg::side_t  side_i,
  input  wire logic               wr_ready_i,
  output logic                    wr_valid_o,
  output sample_pkg::fifo_entry_t wr_entry_o
);

  sample_pkg::sig_t       sig_q;    // Previous watched value
  sample_pkg::side_t      side_q;
  sample_pkg::pkt_count_t count_q;  // Words already captured in this packet
  logic                   last_q;
  logic                   capture;
  logic                   pkt_end;

  // A change is only taken when the FIFO can still hold it
  assign capture = wr_ready_i && (sig_i != sig_q);
  assign pkt_end = (count_q == sample_pkg::pkt_count_t'(`LOG_PACKET_SIZE - 1));

  always_ff @(posedge clock) begin
    if (rst_i || !enable_i) begin
      // All ones, so the first sample after enable usually differs
      sig_q      <= '1;
      count_q    <= '0;
      wr_valid_o <= 1'b0;
      last_q     <= 1'b0;
    end else begin
      sig_q      <= sig_i;  // Updates even when the change is dropped
      wr_valid_o <= capture;  // One-cycle write pulse
      last_q     <= capture && pkt_end;
      if (capture) begin
        count_q <= pkt_end ? '0 : count_q + 1'b1;
      end
    end
  end

  // Side field follows the watched signal into the same word
  always_ff @(posedge clock) begin
    side_q <= side_i;
  end

  assign wr_entry_o = '{
    last: last_q,
    word: '{side: side_q, sig: sig_q}
  };

endmodule

`default_nettype wire

/* source/sample_fifo.sv */
`default_nettype none

`include "logger_consts.svh"

module sample_fifo (
  input  wire logic                     clock,
  input  wire logic                     rst_i,
  input  wire logic                     wr_valid_i,
  input  wire sample_pkg::fifo_entry_t  wr_entry_i,
  output logic                          wr_ready_o,
  output logic                          rd_valid_o,
  output sample_pkg::fifo_entry_t       rd_entry_o,
  input  wire logic                     rd_ready_i,
  output stream_pkg::fifo_level_t       level_o
);

  localparam int PTR_WIDTH = $clog2(`LOG_FIFO_DEPTH);
  localparam stream_pkg::fifo_level_t FULL_LEVEL =
    stream_pkg::fifo_level_t'(`LOG_FIFO_DEPTH);
  localparam stream_pkg::fifo_level_t LAST_FREE =
    stream_pkg::fifo_level_t'(`LOG_FIFO_DEPTH - 1);

  sample_pkg::fifo_entry_t mem_q [`LOG_FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]    wr_ptr_q;
  logic [PTR_WIDTH-1:0]    rd_ptr_q;
  stream_pkg::fifo_level_t count_q;
  logic                    full;
  logic                    wr_fire;
  logic                    rd_fire;

  assign full    = (count_q == FULL_LEVEL);
  assign wr_fire = wr_valid_i && !full;
  assign rd_fire = rd_valid_o && rd_ready_i;

  // The framer decides one cycle before its write lands, so the last
  // free slot counts as taken while a write is arriving
  assign wr_ready_o = wr_valid_i ? (count_q < LAST_FREE) : (count_q <= LAST_FREE);

  // First-word fall-through, head entry is always on the output
  assign rd_valid_o = (count_q != '0);
  assign rd_entry_o = mem_q[rd_ptr_q];
  assign level_o    = count_q;

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      mem_q[wr_ptr_q] <= wr_entry_i;
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
      end
      if (rd_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end

      // Level moves on the same edge as the write or read
      case ({wr_fire, rd_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle, or write and read together
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/word_serializer.sv */
`default_nettype none

`include "logger_consts.svh"

module word_serializer (
  input  wire logic                     clock,
  input  wire logic                     rst_i,
  input  wire logic                     rd_valid_i,
  input  wire sample_pkg::fifo_entry_t  rd_entry_i,
  output logic                          rd_ready_o,
  output logic                          m_tvalid_o,
  input  wire logic                     m_tready_i,
  output stream_pkg::stream_byte_t      m_tdata_o,
  output logic                          m_tlast_o
);

  localparam logic [1:0] LAST_BYTE = 2'(`LOG_WORD_WIDTH / `LOG_BYTE_WIDTH - 1);

  sample_pkg::sample_word_t word_q;
  logic                     last_q;   // Packet end flag of the held word
  logic                     held_q;   // A word is being sent
  logic [1:0]               idx_q;    // Byte currently on the stream
  logic                     byte_fire;
  logic                     word_done;

  assign byte_fire = held_q && m_tready_i;
  assign word_done = byte_fire && (idx_q == LAST_BYTE);

  // Take the next word while the final byte leaves, no bubble between words
  assign rd_ready_o = !held_q || word_done;

  assign m_tvalid_o = held_q;
  assign m_tdata_o  = word_q[{idx_q, 3'b000} +: `LOG_BYTE_WIDTH];  // Low byte first
  assign m_tlast_o  = held_q && last_q && (idx_q == LAST_BYTE);

  always_ff @(posedge clock) begin
    if (rst_i) begin
      held_q <= 1'b0;
      idx_q  <= '0;
    end else if (rd_valid_i && rd_ready_o) begin
      held_q <= 1'b1;
      idx_q  <= '0;
    end else if (word_done) begin
      held_q <= 1'b0;  // FIFO was empty
      idx_q  <= '0;
    end else if (byte_fire) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  // Payload only changes on a load, so it stays stable under back-pressure
  always_ff @(posedge clock) begin
    if (rd_valid_i && rd_ready_o) begin
      word_q <= rd_entry_i.word;
      last_q <= rd_entry_i.last;
    end
  end

endmodule

`default_nettype wire

/* source/telemetry_logger.sv */
`default_nettype none

module telemetry_logger (
  input  wire logic                 clock,
  input  wire logic                 rst_i,
  input  wire logic                 enable_i,
  input  wire sample_pkg::sig_t     sig_i,
  input  wire sample_pkg::side_t    side_i,
  output stream_pkg::fifo_level_t   level_o,
  output logic                      m_tvalid_o,
  input  wire logic                 m_tready_i,
  output stream_pkg::stream_byte_t  m_tdata_o,
  output logic                      m_tlast_o
);

  // Framer to FIFO
  logic                    wr_valid;
  logic                    wr_ready;
  sample_pkg::fifo_entry_t wr_entry;

  // FIFO to serializer
  logic                    rd_valid;
  logic                    rd_ready;
  sample_pkg::fifo_entry_t rd_entry;

  change_framer u_framer (
    .clock      (clock),
    .rst_i      (rst_i),
    .enable_i   (enable_i),
    .sig_i      (sig_i),
    .side_i     (side_i),
    .wr_ready_i (wr_ready),
    .wr_valid_o (wr_valid),
    .wr_entry_o (wr_entry)
  );

  sample_fifo u_fifo (
    .clock      (clock),
    .rst_i      (rst_i),
    .wr_valid_i (wr_valid),
    .wr_entry_i (wr_entry),
    .wr_ready_o (wr_ready),
    .rd_valid_o (rd_valid),
    .rd_entry_o (rd_entry),
    .rd_ready_i (rd_ready),
    .level_o    (level_o)
  );

  word_serializer u_serializer (
    .clock      (clock),
    .rst_i      (rst_i),
    .rd_valid_i (rd_valid),
    .rd_entry_i (rd_entry),
    .rd_ready_o (rd_ready),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tdata_o  (m_tdata_o),
    .m_tlast_o  (m_tlast_o)
  );

endmodule

`default_nettype wire

/* verification/telemetry_logger_tb.sv */
`default_nettype none

`include "logger_consts.svh"

module telemetry_logger_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // Test lengths in changes or cycles
  localparam int T1_CHANGES = 10;
  localparam int T1_GAP     = 6;
  localparam int T2_CYCLES  = 20;
  localparam int T3_CHANGES = 20;
  localparam int T3_GAP     = 4;
  localparam int T3_AFTER   = 10;
  localparam int T4_CHANGES = 40;
  localparam int T4_GAP     = 6;
  localparam int T5_CHANGES = 30;
  localparam int STIM_CYCLES = 5 + T1_CHANGES * T1_GAP + T2_CYCLES + T3_CHANGES * T3_GAP + 6
    + T3_AFTER * T3_GAP + T4_CHANGES * T4_GAP + T5_CHANGES + 6;
  localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 200;

  localparam stream_pkg::fifo_level_t FULL_LEVEL = stream_pkg::fifo_level_t'(`LOG_FIFO_DEPTH);

  // One expected stream byte with its last flag
  typedef struct packed {
    logic                     last;
    stream_pkg::stream_byte_t data;
  } beat_t;

  typedef beat_t [3:0] word_beats_t;

  logic                     clock = 1'b0;
  logic                     rst_i;
  logic                     enable_i;
  sample_pkg::sig_t         sig_i;
  sample_pkg::side_t        side_i;
  stream_pkg::fifo_level_t  level_o;
  logic                     m_tvalid_o;
  logic                     m_tready_i;
  stream_pkg::stream_byte_t m_tdata_o;
  logic                     m_tlast_o;

  integer           seed;
  beat_t            exp_q[$];       // Bytes the stream still owes
  sample_pkg::sig_t model_prev;
  int               model_count;    // Word position inside the packet
  logic             model_pending;  // Capture from the previous edge with its write in flight
  int               dropped_count = 0;
  int               cycle_count   = 0;
  logic             stalled       = 1'b0;
  beat_t            stall_beat;

  telemetry_logger dut_i (
    .clock      (clock),
    .rst_i      (rst_i),
    .enable_i   (enable_i),
    .sig_i      (sig_i),
    .side_i     (side_i),
    .level_o    (level_o),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tdata_o  (m_tdata_o),
    .m_tlast_o  (m_tlast_o)
  );

  always #2 clock = ~clock;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at %0d ns", $time);
  endtask

  task automatic check_byte(input stream_pkg::stream_byte_t got,
                            input stream_pkg::stream_byte_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_level(input stream_pkg::fifo_level_t got,
                             input stream_pkg::fifo_level_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_level_bound(input stream_pkg::fifo_level_t got);
    if (got > FULL_LEVEL) begin
      abort_run($sformatf("[FAIL] %0d ns: level_o is %0d, above %0d", $time, got, FULL_LEVEL));
    end
  endtask

  // Four beats of one captured word with the watched signal low byte first
  function automatic word_beats_t expected_beats(input sample_pkg::sig_t sig,
                                                 input sample_pkg::side_t side,
                                                 input logic pkt_last);
    word_beats_t beats;
    beats[0] = '{last: 1'b0, data: sig[7:0]};
    beats[1] = '{last: 1'b0, data: sig[15:8]};
    beats[2] = '{last: 1'b0, data: side[7:0]};
    beats[3] = '{last: pkt_last, data: side[15:8]};
    return beats;
  endfunction

  // Reference model of change capture
  always @(posedge clock) begin
    word_beats_t beats;
    logic        changed;
    logic        room;
    if (rst_i || !enable_i) begin
      model_prev    = '1;
      model_count   = 0;
      model_pending = 1'b0;
    end else begin
      changed = (sig_i != model_prev);
      // Free slot once the write already in flight has landed
      room = (int'(level_o) + int'(model_pending)) < `LOG_FIFO_DEPTH;
      if (changed && room) begin
        beats = expected_beats(sig_i, side_i, model_count == `LOG_PACKET_SIZE - 1);
        for (int i = 0; i < 4; i++) begin
          exp_q.push_back(beats[i]);
        end
        model_count = (model_count + 1) % `LOG_PACKET_SIZE;
      end else if (changed) begin
        dropped_count++;
      end
      model_pending = changed && room;
      model_prev    = sig_i;
    end
    if (!rst_i) begin
      check_level_bound(level_o);
    end
  end

  // Stream compare
  always @(posedge clock) begin
    beat_t beat;
    if (!rst_i) begin
      if (stalled) begin  // Byte must hold while not accepted
        check_flag(m_tvalid_o, 1'b1, "m_tvalid during stall");
        check_byte(m_tdata_o, stall_beat.data, "m_tdata during stall");
        check_flag(m_tlast_o, stall_beat.last, "m_tlast during stall");
      end
      if (m_tvalid_o && m_tready_i) begin
        if (exp_q.size() == 0) begin
          abort_run("A stream byte arrived while no byte was expected");
        end else begin
          beat = exp_q.pop_front();
          check_byte(m_tdata_o, beat.data, "m_tdata");
          check_flag(m_tlast_o, beat.last, "m_tlast");
        end
      end
      stalled    = m_tvalid_o && !m_tready_i;
      stall_beat = '{last: m_tlast_o, data: m_tdata_o};
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout after %0d cycles, the stream did not drain", cycle_count));
    end
  end

  task automatic drive_change();
    logic [31:0]      rnd;
    sample_pkg::sig_t next_sig;
    rnd      = $random(seed);
    next_sig = rnd[15:0];
    if (next_sig == sig_i) begin
      next_sig = ~next_sig;  // Always a real change
    end
    rnd = $random(seed);
    sig_i  <= next_sig;
    side_i <= rnd[15:0];
  endtask

  task automatic next_cycle(input logic random_ready);
    logic [31:0] rnd;
    @(posedge clock);
    if (random_ready) begin
      rnd = $random(seed);
      m_tready_i <= (rnd[1:0] != 2'b00);  // Ready three cycles in four
    end
  endtask

  task automatic run_changes(input int count, input int gap, input logic random_ready);
    repeat (count) begin
      next_cycle(random_ready);
      drive_change();
      repeat (gap - 1) begin
        next_cycle(random_ready);
      end
    end
  endtask

  task automatic wait_for_drain();
    repeat (3) @(posedge clock);  // Let the last capture reach the model
    do begin
      @(posedge clock);
    end while (exp_q.size() != 0 || m_tvalid_o);
  endtask

  initial begin
    logic [31:0] rnd;
    int          dropped_before;
    seed       = 32'h2594_af53;
    rst_i      <= 1'b1;
    enable_i   <= 1'b0;
    sig_i      <= '0;
    side_i     <= '0;
    m_tready_i <= 1'b0;
    repeat (5) @(posedge clock);
    rst_i      <= 1'b0;
    enable_i   <= 1'b1;
    m_tready_i <= 1'b1;

    // Isolated changes with the stream always ready
    run_changes(T1_CHANGES, T1_GAP, 1'b0);
    wait_for_drain();

    // Only the side field moves
    repeat (T2_CYCLES) begin
      @(posedge clock);
      rnd = $random(seed);
      side_i <= rnd[15:0];
    end
    wait_for_drain();

    // Packet framing followed by a disable and a restart at all ones
    run_changes(T3_CHANGES, T3_GAP, 1'b0);
    @(posedge clock);
    enable_i <= 1'b0;
    sig_i    <= '1;
    repeat (3) @(posedge clock);
    enable_i <= 1'b1;
    repeat (2) @(posedge clock);
    run_changes(T3_AFTER, T3_GAP, 1'b0);
    wait_for_drain();

    // Random back-pressure
    dropped_before = dropped_count;
    run_changes(T4_CHANGES, T4_GAP, 1'b1);
    @(posedge clock);
    m_tready_i <= 1'b1;
    wait_for_drain();
    if (dropped_count != dropped_before) begin
      abort_run("Changes were dropped under random back-pressure");
    end

    // Stalled stream during a burst fills the FIFO
    @(posedge clock);
    m_tready_i <= 1'b0;
    dropped_before = dropped_count;
    run_changes(T5_CHANGES, 1, 1'b0);
    repeat (3) @(posedge clock);
    check_level(level_o, FULL_LEVEL, "level_o after stalled burst");
    if (dropped_count == dropped_before) begin
      abort_run("No change was dropped while the FIFO was full");
    end
    @(posedge clock);
    m_tready_i <= 1'b1;
    wait_for_drain();
    check_level(level_o, '0, "level_o after drain");

    if (exp_q.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run("Expected stream bytes never arrived");
    end
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/sample_pkg.sv
common/stream_pkg.sv
framer/change_framer.sv
source/sample_fifo.sv
source/word_serializer.sv
source/telemetry_logger.sv
verification/telemetry_logger_tb.sv

/* Makefile */
# Verilator build and run for the telemetry logger testbench

VERILATOR ?= verilator
TOP       ?= telemetry_logger_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

PASS_TEXT := Finished with no errors
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard common/*.svh)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
